// File: Makefile
SIM = obj_dir/Vintersection_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep "Regression passed" > /dev/null

$(SIM): build.f $(wildcard source/*.sv tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module intersection_tb -f build.f

clean:
	rm -rf obj_dir

// File: build.f
source/timing_pkg.sv
source/signal_pkg.sv
source/phase_timer.sv
source/ped_request_latch.sv
source/traffic_controller.sv
source/intersection_top.sv
tb/tb_clock_gen.sv
tb/intersection_checker.sv
tb/intersection_tb.sv

// File: source/intersection_top.sv
`timescale 1ns/1ps

module intersection_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tick,
    input  logic                        ped_button,
    input  logic                        emergency,
    output signal_pkg::signal_heads_t   heads,
    output signal_pkg::status_t         status
);

    logic ped_pending;
    logic ped_grant;

    ped_request_latch i_ped_request_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .ped_button  (ped_button),
        .ped_grant   (ped_grant),
        .ped_pending (ped_pending)
    );

    traffic_controller i_traffic_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .emergency   (emergency),
        .ped_pending (ped_pending),
        .ped_grant   (ped_grant),
        .heads       (heads),
        .status      (status)
    );

endmodule

// File: source/ped_request_latch.sv
`timescale 1ns/1ps

module ped_request_latch (
    input  logic clk,
    input  logic rst_n,
    input  logic ped_button,
    input  logic ped_grant,
    output logic ped_pending
);

    // A press on the grant cycle is kept for the next crossing.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ped_pending <= 1'b0;
        end else if (ped_button) begin
            ped_pending <= 1'b1;
        end else if (ped_grant) begin
            ped_pending <= 1'b0;
        end
    end

endmodule

// File: source/phase_timer.sv
`timescale 1ns/1ps

module phase_timer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            tick,
    input  logic                            load,
    input  logic [timing_pkg::TIMER_W-1:0]  load_value,
    output logic                            expire
);

    logic [timing_pkg::TIMER_W-1:0] count;

    // Load wins over a tick on the same edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= timing_pkg::STARTUP_TICKS;
        end else if (load) begin
            count <= load_value;
        end else if (tick && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // High on the last tick of the phase.
    assign expire = tick && (count == timing_pkg::TIMER_W'(1));

endmodule

// File: source/signal_pkg.sv
package signal_pkg;

    // Lamp lit on one signal head.
    typedef enum logic [1:0] {
        DARK   = 2'd0,
        RED    = 2'd1,
        YELLOW = 2'd2,
        GREEN  = 2'd3
    } lamp_t;

    // Both signal heads of the intersection.
    typedef struct packed {
        lamp_t ns;
        lamp_t ew;
    } signal_heads_t;

    // Controller status seen from outside.
    typedef struct packed {
        logic                walk;
        logic                emergency_active;
        timing_pkg::phase_t  phase;
    } status_t;

endpackage

// File: source/timing_pkg.sv
package timing_pkg;

    // Controller states, also reported on the status output.
    typedef enum logic [2:0] {
        STARTUP_FLASH       = 3'd0,
        NS_GREEN_EW_RED     = 3'd1,
        NS_YELLOW_EW_RED    = 3'd2,
        NS_RED_EW_GREEN     = 3'd3,
        NS_RED_EW_YELLOW    = 3'd4,
        PEDESTRIAN_CROSSING = 3'd5,
        EMERGENCY_ALL_RED   = 3'd6
    } phase_t;

    // Width of the phase down counter.
    localparam int TIMER_W = 8;

    // Phase durations, counted in ticks.
    localparam logic [TIMER_W-1:0] STARTUP_TICKS = 8'd4;
    localparam logic [TIMER_W-1:0] GREEN_TICKS   = 8'd30;
    localparam logic [TIMER_W-1:0] YELLOW_TICKS  = 8'd5;
    localparam logic [TIMER_W-1:0] WALK_TICKS    = 8'd20;

endpackage

// File: source/traffic_controller.sv
`timescale 1ns/1ps

module traffic_controller (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tick,
    input  logic                        emergency,
    input  logic                        ped_pending,
    output logic                        ped_grant,
    output signal_pkg::signal_heads_t   heads,
    output signal_pkg::status_t         status
);

    timing_pkg::phase_t             state;
    timing_pkg::phase_t             next_state;
    logic                           load;
    logic [timing_pkg::TIMER_W-1:0] load_value;
    logic                           expire;
    logic                           flash;

    phase_timer i_phase_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .load       (load),
        .load_value (load_value),
        .expire     (expire)
    );

    function automatic logic [timing_pkg::TIMER_W-1:0] phase_ticks(
        input timing_pkg::phase_t phase
    );
        case (phase)
            timing_pkg::STARTUP_FLASH:       phase_ticks = timing_pkg::STARTUP_TICKS;
            timing_pkg::NS_YELLOW_EW_RED:    phase_ticks = timing_pkg::YELLOW_TICKS;
            timing_pkg::NS_RED_EW_YELLOW:    phase_ticks = timing_pkg::YELLOW_TICKS;
            timing_pkg::PEDESTRIAN_CROSSING: phase_ticks = timing_pkg::WALK_TICKS;
            default:                         phase_ticks = timing_pkg::GREEN_TICKS;
        endcase
    endfunction

    // Emergency preempts every phase; expire is ignored while it holds.
    always_comb begin
        next_state = state;
        if (emergency && (state != timing_pkg::EMERGENCY_ALL_RED)) begin
            next_state = timing_pkg::EMERGENCY_ALL_RED;
        end else begin
            case (state)
                timing_pkg::EMERGENCY_ALL_RED: begin
                    if (!emergency)
                        next_state = timing_pkg::NS_GREEN_EW_RED;
                end
                timing_pkg::STARTUP_FLASH: begin
                    if (expire)
                        next_state = timing_pkg::NS_GREEN_EW_RED;
                end
                timing_pkg::NS_GREEN_EW_RED: begin
                    if (expire)
                        next_state = timing_pkg::NS_YELLOW_EW_RED;
                end
                timing_pkg::NS_YELLOW_EW_RED: begin
                    if (expire)
                        next_state = timing_pkg::NS_RED_EW_GREEN;
                end
                timing_pkg::NS_RED_EW_GREEN: begin
                    if (expire)
                        next_state = timing_pkg::NS_RED_EW_YELLOW;
                end
                timing_pkg::NS_RED_EW_YELLOW: begin
                    if (expire && ped_pending)
                        next_state = timing_pkg::PEDESTRIAN_CROSSING;
                    else if (expire)
                        next_state = timing_pkg::NS_GREEN_EW_RED;
                end
                timing_pkg::PEDESTRIAN_CROSSING: begin
                    if (expire)
                        next_state = timing_pkg::NS_GREEN_EW_RED;
                end
                default: next_state = timing_pkg::STARTUP_FLASH;
            endcase
        end
    end

    // Every transition loads the new phase length, except into all-red.
    assign load       = (next_state != state) && (next_state != timing_pkg::EMERGENCY_ALL_RED);
    assign load_value = phase_ticks(next_state);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= timing_pkg::STARTUP_FLASH;
            ped_grant <= 1'b0;
            flash     <= 1'b0;
        end else begin
            state     <= next_state;
            ped_grant <= (next_state == timing_pkg::PEDESTRIAN_CROSSING) &&
                         (state != timing_pkg::PEDESTRIAN_CROSSING);
            if (tick && (state == timing_pkg::STARTUP_FLASH))
                flash <= ~flash;
        end
    end

    // Lamp and status decode.
    always_comb begin
        heads.ns                = signal_pkg::RED;
        heads.ew                = signal_pkg::RED;
        status.walk             = 1'b0;
        status.emergency_active = 1'b0;
        status.phase            = state;
        case (state)
            timing_pkg::STARTUP_FLASH: begin
                heads.ns = flash ? signal_pkg::YELLOW : signal_pkg::DARK;
                heads.ew = flash ? signal_pkg::YELLOW : signal_pkg::DARK;
            end
            timing_pkg::NS_GREEN_EW_RED:     heads.ns = signal_pkg::GREEN;
            timing_pkg::NS_YELLOW_EW_RED:    heads.ns = signal_pkg::YELLOW;
            timing_pkg::NS_RED_EW_GREEN:     heads.ew = signal_pkg::GREEN;
            timing_pkg::NS_RED_EW_YELLOW:    heads.ew = signal_pkg::YELLOW;
            timing_pkg::PEDESTRIAN_CROSSING: status.walk = 1'b1;
            timing_pkg::EMERGENCY_ALL_RED:   status.emergency_active = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: tb/intersection_checker.sv
`timescale 1ns/1ps

module intersection_checker (
    input logic                        clk,
    input logic                        rst_n,
    input signal_pkg::signal_heads_t   heads,
    input signal_pkg::status_t         status
);

    logic green_clash     = 1'b0;
    logic walk_clash      = 1'b0;
    logic emergency_clash = 1'b0;
    logic any_violation;

    assign any_violation = green_clash | walk_clash | emergency_clash;

    a_no_double_green: assert property (@(posedge clk) disable iff (!rst_n)
        !((heads.ns == signal_pkg::GREEN) && (heads.ew == signal_pkg::GREEN)))
    else begin
        green_clash = 1'b1;
        $error("Both heads show green");
    end

    // Crossing pedestrians only ever see red traffic.
    a_walk_all_red: assert property (@(posedge clk) disable iff (!rst_n)
        status.walk |-> ((heads.ns == signal_pkg::RED) && (heads.ew == signal_pkg::RED)))
    else begin
        walk_clash = 1'b1;
        $error("Walk is set while a head is not red");
    end

    a_emergency_all_red: assert property (@(posedge clk) disable iff (!rst_n)
        status.emergency_active |->
            ((heads.ns == signal_pkg::RED) && (heads.ew == signal_pkg::RED)))
    else begin
        emergency_clash = 1'b1;
        $error("Emergency is active while a head is not red");
    end

endmodule

// File: tb/intersection_tb.sv
`timescale 1ns/1ps

module intersection_tb;

    localparam int DIRECTED_TICKS = 900;
    localparam int RANDOM_TICKS   = 3000;
    localparam int WATCHDOG_NS    = (DIRECTED_TICKS + RANDOM_TICKS) * 5 * 4 + 2000;
    localparam int CYCLE_TICKS    = 2 * int'(timing_pkg::GREEN_TICKS) +
                                    2 * int'(timing_pkg::YELLOW_TICKS);

    typedef struct packed {
        logic rst_n;
        logic tick;
        logic press;
        logic emergency;
    } stim_t;

    typedef struct packed {
        timing_pkg::phase_t             phase;
        logic [timing_pkg::TIMER_W-1:0] count;
        logic                           flash;
        logic                           pending;
        logic                           grant;
    } model_t;

    logic                      clk;
    logic                      rst_n;
    logic                      tick;
    logic                      ped_button;
    logic                      emergency;
    signal_pkg::signal_heads_t heads;
    signal_pkg::status_t       status;

    int                 seed = 83;
    logic               emerg_level = 1'b0;
    model_t             model;
    bit                 model_valid = 1'b0;
    timing_pkg::phase_t seen_phase;
    int                 ticks_seen;

    tb_clock_gen i_clock_gen (
        .clk (clk)
    );

    intersection_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .ped_button (ped_button),
        .emergency  (emergency),
        .heads      (heads),
        .status     (status)
    );

    bind traffic_controller intersection_checker i_checker (
        .clk    (clk),
        .rst_n  (rst_n),
        .heads  (heads),
        .status (status)
    );

    function automatic int draw(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [timing_pkg::TIMER_W-1:0] phase_duration(
        input timing_pkg::phase_t phase
    );
        case (phase)
            timing_pkg::STARTUP_FLASH:       return timing_pkg::STARTUP_TICKS;
            timing_pkg::NS_YELLOW_EW_RED:    return timing_pkg::YELLOW_TICKS;
            timing_pkg::NS_RED_EW_YELLOW:    return timing_pkg::YELLOW_TICKS;
            timing_pkg::PEDESTRIAN_CROSSING: return timing_pkg::WALK_TICKS;
            default:                         return timing_pkg::GREEN_TICKS;
        endcase
    endfunction

    // One clock of the intersection, seen from its outside rules.
    function automatic model_t next_model(input model_t cur, input stim_t in);
        model_t nxt;
        logic   expire;
        nxt = cur;
        expire = in.tick && (cur.count == timing_pkg::TIMER_W'(1));
        if (!in.rst_n) begin
            nxt.phase   = timing_pkg::STARTUP_FLASH;
            nxt.count   = timing_pkg::STARTUP_TICKS;
            nxt.flash   = 1'b0;
            nxt.pending = 1'b0;
            nxt.grant   = 1'b0;
        end else begin
            nxt.pending = in.press | (cur.pending & ~cur.grant);
            if (in.emergency && (cur.phase != timing_pkg::EMERGENCY_ALL_RED)) begin
                nxt.phase = timing_pkg::EMERGENCY_ALL_RED;
            end else if (cur.phase == timing_pkg::EMERGENCY_ALL_RED) begin
                if (!in.emergency)
                    nxt.phase = timing_pkg::NS_GREEN_EW_RED;
            end else if (expire) begin
                case (cur.phase)
                    timing_pkg::NS_GREEN_EW_RED:  nxt.phase = timing_pkg::NS_YELLOW_EW_RED;
                    timing_pkg::NS_YELLOW_EW_RED: nxt.phase = timing_pkg::NS_RED_EW_GREEN;
                    timing_pkg::NS_RED_EW_GREEN:  nxt.phase = timing_pkg::NS_RED_EW_YELLOW;
                    timing_pkg::NS_RED_EW_YELLOW:
                        nxt.phase = cur.pending ? timing_pkg::PEDESTRIAN_CROSSING
                                                : timing_pkg::NS_GREEN_EW_RED;
                    default:                      nxt.phase = timing_pkg::NS_GREEN_EW_RED;
                endcase
            end
            if ((nxt.phase != cur.phase) && (nxt.phase != timing_pkg::EMERGENCY_ALL_RED))
                nxt.count = phase_duration(nxt.phase);
            else if (in.tick && (cur.count != '0))
                nxt.count = cur.count - 1'b1;
            if (in.tick && (cur.phase == timing_pkg::STARTUP_FLASH))
                nxt.flash = ~cur.flash;
            nxt.grant = (nxt.phase == timing_pkg::PEDESTRIAN_CROSSING) &&
                        (cur.phase != timing_pkg::PEDESTRIAN_CROSSING);
        end
        return nxt;
    endfunction

    function automatic signal_pkg::signal_heads_t expected_heads(input model_t m);
        signal_pkg::signal_heads_t h;
        h.ns = signal_pkg::RED;
        h.ew = signal_pkg::RED;
        case (m.phase)
            timing_pkg::STARTUP_FLASH: begin
                h.ns = m.flash ? signal_pkg::YELLOW : signal_pkg::DARK;
                h.ew = h.ns;
            end
            timing_pkg::NS_GREEN_EW_RED:  h.ns = signal_pkg::GREEN;
            timing_pkg::NS_YELLOW_EW_RED: h.ns = signal_pkg::YELLOW;
            timing_pkg::NS_RED_EW_GREEN:  h.ew = signal_pkg::GREEN;
            timing_pkg::NS_RED_EW_YELLOW: h.ew = signal_pkg::YELLOW;
            default: ;
        endcase
        return h;
    endfunction

    function automatic signal_pkg::status_t expected_status(input model_t m);
        signal_pkg::status_t s;
        s.walk             = (m.phase == timing_pkg::PEDESTRIAN_CROSSING);
        s.emergency_active = (m.phase == timing_pkg::EMERGENCY_ALL_RED);
        s.phase            = m.phase;
        return s;
    endfunction

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_heads(
        input signal_pkg::signal_heads_t got,
        input signal_pkg::signal_heads_t exp
    );
        if (got !== exp) begin
            $display("FAILED at %0t: heads ns=%s ew=%s, expected ns=%s ew=%s", $time,
                     got.ns.name(), got.ew.name(), exp.ns.name(), exp.ew.name());
            stop_run();
        end
    endtask

    task automatic check_status(input signal_pkg::status_t got, input signal_pkg::status_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: status %s walk=%b emerg=%b, expected %s walk=%b emerg=%b",
                     $time, got.phase.name(), got.walk, got.emergency_active,
                     exp.phase.name(), exp.walk, exp.emergency_active);
            stop_run();
        end
    endtask

    task automatic check_ticks(input timing_pkg::phase_t phase, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: %s lasted %0d ticks, expected %0d",
                     $time, phase.name(), got, exp);
            stop_run();
        end
    endtask

    task automatic drive_cycle(input logic t, input logic press);
        @(posedge clk);
        tick       <= t;
        ped_button <= press;
        emergency  <= emerg_level;
    endtask

    task automatic run_ticks(input int n);
        repeat (n) begin
            repeat (1 + draw(4)) drive_cycle(1'b0, 1'b0);
            drive_cycle(1'b1, 1'b0);
        end
    endtask

    task automatic press_button();
        drive_cycle(1'b0, 1'b1);
    endtask

    task automatic hold_emergency(input int n);
        emerg_level = 1'b1;
        run_ticks(n);
        emerg_level = 1'b0;
        drive_cycle(1'b0, 1'b0);
    endtask

    task automatic wait_phase(input timing_pkg::phase_t p, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (status.phase != p) begin
            if (n >= limit) begin
                $display("Phase %s was not reached within %0d ticks", p.name(), limit);
                stop_run();
            end
            run_ticks(1);
            n++;
            @(negedge clk);
        end
    endtask

    task automatic random_run(input int n);
        int hold;
        hold = 0;
        repeat (n) begin
            if (hold > 0) begin
                hold--;
                if (hold == 0)
                    emerg_level = 1'b0;
            end else if (draw(120) == 0) begin
                emerg_level = 1'b1;
                hold = 1 + draw(5);
            end
            repeat (1 + draw(4)) drive_cycle(1'b0, draw(50) == 0);
            drive_cycle(1'b1, draw(50) == 0);
        end
        emerg_level = 1'b0;
    endtask

    // Outputs are stable at the falling edge; inputs seen here reach the next rising edge.
    always @(negedge clk) begin
        if (i_dut.i_traffic_controller.i_checker.any_violation) begin
            $display("A lamp safety assertion fired");
            stop_run();
        end
        if (model_valid) begin
            check_heads(heads, expected_heads(model));
            check_status(status, expected_status(model));
        end
        model = next_model(model, {rst_n, tick, ped_button, emergency});
        model_valid = 1'b1;
    end

    // Ticks spent in each phase that ends by expiring.
    always @(negedge clk) begin
        if (!rst_n) begin
            seen_phase = timing_pkg::STARTUP_FLASH;
            ticks_seen = 0;
        end else begin
            if (status.phase != seen_phase) begin
                if ((seen_phase != timing_pkg::EMERGENCY_ALL_RED) &&
                    (status.phase != timing_pkg::EMERGENCY_ALL_RED))
                    check_ticks(seen_phase, ticks_seen, int'(phase_duration(seen_phase)));
                seen_phase = status.phase;
                ticks_seen = 0;
            end
            if (tick)
                ticks_seen++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        stop_run();
    end

    initial begin
        rst_n      <= 1'b0;
        tick       <= 1'b0;
        ped_button <= 1'b0;
        emergency  <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Startup flash, then two cycles without requests.
        run_ticks(int'(timing_pkg::STARTUP_TICKS) + 2 * CYCLE_TICKS);

        press_button();
        wait_phase(timing_pkg::PEDESTRIAN_CROSSING, 100);
        run_ticks(3);
        press_button();
        wait_phase(timing_pkg::NS_GREEN_EW_RED, 100);
        wait_phase(timing_pkg::PEDESTRIAN_CROSSING, 100);
        wait_phase(timing_pkg::NS_GREEN_EW_RED, 100);

        // Preemption mid green with a call waiting, then mid walk.
        run_ticks(10);
        press_button();
        hold_emergency(3);
        wait_phase(timing_pkg::PEDESTRIAN_CROSSING, 100);
        run_ticks(5);
        hold_emergency(3);
        wait_phase(timing_pkg::NS_RED_EW_GREEN, 100);

        random_run(RANDOM_TICKS);
        repeat (4) drive_cycle(1'b0, 1'b0);

        if (!i_dut.i_traffic_controller.i_checker.any_violation) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("A lamp safety assertion fired during the run");
            stop_run();
        end
    end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // Half of the 4 ns period.
    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule
